//--- design/chip_cfg_pkg.sv
//----------------------------------------------------------
// Pad configuration shared definitions
// Widths, strap depth, the configuration mode encoding and
// the packed pad and SoC drive bundles
//----------------------------------------------------------
`default_nettype none

package chip_cfg_pkg;

  //----------------------------------------------------------
  // Sizes
  //----------------------------------------------------------
  localparam int GPIO_TIO    = 4; // Reconfigurable pins per GPIO group
  localparam int STRAP_DEPTH = 8; // Strap and reset shift register length

  typedef logic [GPIO_TIO-1:0] tio_vec_t; // One GPIO group or test data

  //----------------------------------------------------------
  // Configuration mode
  //----------------------------------------------------------
  typedef enum logic [1:0] {
    CFG_SYS  = 2'b00, // Debug wire on alternate pins, pulldown default
    CFG_ALT  = 2'b01, // UART on alternate pins
    CFG_BIST = 2'b10, // Self test through GPIO
    CFG_SCAN = 2'b11  // Scan test through GPIO
  } cfg_mode_e;

  // One-hot selection, all clear until capture
  typedef struct packed {
    logic sys;
    logic alt;
    logic bist;
    logic scan;
  } cfg_sel_t;

  //----------------------------------------------------------
  // Tristate drive bundles
  //----------------------------------------------------------
  typedef struct packed {
    tio_vec_t o; // Output data
    tio_vec_t e; // Output enable, active high
  } gpio_drv_t;

  typedef struct packed {
    logic o; // Output data
    logic e; // Output enable, active high
  } pin_drv_t;

endpackage

`default_nettype wire

//--- design/por_sequencer.sv
//----------------------------------------------------------
// Power-on reset sequencer
// Synchronises the pad reset and steps through the early
// reset, strap sample strobes, capture strobe and SoC reset
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module por_sequencer (
  input  wire  pad_clk_i,     // Pad clock
  input  wire  pad_nrst_i,    // Raw pad reset, active low
  output logic nrst_early_o,  // Early reset for config state
  output logic strap_win_o,   // Strap shifting window
  output logic sample_stb_o,  // Update candidate mode
  output logic capture_stb_o, // Latch the final mode
  output logic soc_nreset_o   // Delayed SoC reset
);

  import chip_cfg_pkg::*;

  logic [STRAP_DEPTH-1:0] nrst_sr; // Ones enter at the top, shift right

  //----------------------------------------------------------
  // Reset shift register
  //----------------------------------------------------------
  always_ff @(posedge pad_clk_i or negedge pad_nrst_i) begin
    if (!pad_nrst_i) begin
      nrst_sr <= '0;
    end else if (!nrst_sr[0]) begin // Freeze once full
      nrst_sr <= {1'b1, nrst_sr[STRAP_DEPTH-1:1]};
    end
  end

  //----------------------------------------------------------
  // Strobe decode from adjacent stages
  //----------------------------------------------------------
  // Second stage set after edge 2
  assign nrst_early_o  = nrst_sr[STRAP_DEPTH-2];

  // Open during reset, closes after edge 8
  assign strap_win_o   = !nrst_sr[0];

  // Cycles after edges 2 to 5
  assign sample_stb_o  = nrst_sr[STRAP_DEPTH-2] & !nrst_sr[2];

  // Single cycle after edge 6
  assign capture_stb_o = nrst_sr[2] & !nrst_sr[1];

  // Last stage, rises after edge 8
  assign soc_nreset_o  = nrst_sr[0];

  // Capture is a single pulse
  capture_single_a : assert property (
    @(posedge pad_clk_i) disable iff (!pad_nrst_i)
    capture_stb_o |=> !capture_stb_o
  ) else $error("capture strobe held for more than one cycle");

endmodule

`default_nettype wire

//--- design/test_strap_sampler.sv
//----------------------------------------------------------
// TEST pin strap sampler
// Shifts the TEST pin across the reset release and
// classifies it as rising, falling, high or low to pick
// the candidate configuration mode
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module test_strap_sampler (
  input  wire                    pad_clk_i,    // Pad clock
  input  wire                    pad_nrst_i,   // Clears strap history
  input  wire                    nrst_early,   // Early reset, active low
  input  wire                    pad_test_i,   // TEST pad input
  input  wire                    strap_win_i,  // Shift enable
  input  wire                    sample_stb_i, // Update candidate
  output chip_cfg_pkg::cfg_mode_e mode_o       // Candidate mode
);

  import chip_cfg_pkg::*;

  logic [STRAP_DEPTH-1:0] strap_sr;  // Newest sample at the top
  logic                   test_rise; // Low first, high last
  logic                   test_fall; // High first, low last
  logic                   test_hi;   // High on every sample
  cfg_mode_e              mode_nxt;  // Priority decode

  //----------------------------------------------------------
  // Strap history
  //----------------------------------------------------------
  always_ff @(posedge pad_clk_i or negedge pad_nrst_i) begin
    if (!pad_nrst_i) begin
      strap_sr <= '0;
    end else if (strap_win_i) begin
      strap_sr <= {pad_test_i, strap_sr[STRAP_DEPTH-1:1]};
    end
  end

  // At the last sample strobe the top five stages hold the
  // pin from edges 1 to 5 after release, oldest at the bottom
  assign test_rise = strap_sr[STRAP_DEPTH-1] & !strap_sr[STRAP_DEPTH-5];
  assign test_fall = !strap_sr[STRAP_DEPTH-1] & strap_sr[STRAP_DEPTH-5];
  assign test_hi   = &strap_sr[STRAP_DEPTH-1:STRAP_DEPTH-5];

  always_comb begin
    if (test_rise) begin
      mode_nxt = CFG_ALT;  // Raised with the release
    end else if (test_fall) begin
      mode_nxt = CFG_BIST; // Dropped with the release
    end else if (test_hi) begin
      mode_nxt = CFG_SCAN; // Pullup strap
    end else begin
      mode_nxt = CFG_SYS;  // Held low or glitchy
    end
  end

  //----------------------------------------------------------
  // Candidate mode, last strobe wins
  //----------------------------------------------------------
  always_ff @(posedge pad_clk_i or negedge nrst_early) begin
    if (!nrst_early) begin
      mode_o <= CFG_SYS;
    end else if (sample_stb_i) begin
      mode_o <= mode_nxt;
    end
  end

endmodule

`default_nettype wire

//--- design/cfg_mode_latch.sv
//----------------------------------------------------------
// Configuration mode latch
// Converts the candidate mode to a one-hot selection and
// holds it from the capture strobe until the next reset
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cfg_mode_latch (
  input  wire                     pad_clk_i,     // Pad clock
  input  wire                     nrst_early,    // Early reset, active low
  input  wire                     capture_stb_i, // Load strobe
  input  wire chip_cfg_pkg::cfg_mode_e mode_i,   // Candidate mode
  output chip_cfg_pkg::cfg_sel_t  sel_o          // One-hot selection
);

  import chip_cfg_pkg::*;

  cfg_sel_t sel_nxt; // Decoded flags

  always_comb begin
    sel_nxt = '0;
    case (mode_i)
      CFG_SYS:  sel_nxt.sys  = 1'b1;
      CFG_ALT:  sel_nxt.alt  = 1'b1;
      CFG_BIST: sel_nxt.bist = 1'b1;
      CFG_SCAN: sel_nxt.scan = 1'b1;
      default:  sel_nxt      = '0;
    endcase
  end

  always_ff @(posedge pad_clk_i or negedge nrst_early) begin
    if (!nrst_early) begin
      sel_o <= '0; // Pads idle until configured
    end else if (capture_stb_i) begin
      sel_o <= sel_nxt;
    end
  end

  // Exactly one flag after capture, and it stays put
  sel_onehot_a : assert property (
    @(posedge pad_clk_i) disable iff (!nrst_early)
    capture_stb_i |=> $onehot(sel_o)
  ) else $error("mode selection not one-hot after capture");

  sel_hold_a : assert property (
    @(posedge pad_clk_i) disable iff (!nrst_early)
    (|sel_o) |=> $stable(sel_o)
  ) else $error("mode selection changed after capture");

endmodule

`default_nettype wire

//--- design/pad_mux.sv
//----------------------------------------------------------
// Pad multiplexer
// Routes the alternate pins and both GPIO groups between
// the pads and the SoC for debug, UART or test modes
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pad_mux (
  input  wire chip_cfg_pkg::cfg_sel_t  sel_i,         // Captured mode
  // Alternate pins
  input  wire                          pad_altin_i,   // SWCLK / RXD / test enable
  input  wire                          pad_altio_i,   // SWDIO / TXD pad input
  output chip_cfg_pkg::pin_drv_t       pad_altio_o,   // SWDIO / TXD pad drive
  // GPIO group 0
  input  wire chip_cfg_pkg::tio_vec_t  pad_gpio0_i,
  output chip_cfg_pkg::gpio_drv_t      pad_gpio0_o,
  input  wire chip_cfg_pkg::gpio_drv_t soc_gpio0_i,
  output chip_cfg_pkg::tio_vec_t       soc_gpio0_o,
  // GPIO group 1
  input  wire chip_cfg_pkg::tio_vec_t  pad_gpio1_i,
  output chip_cfg_pkg::gpio_drv_t      pad_gpio1_o,
  input  wire chip_cfg_pkg::gpio_drv_t soc_gpio1_i,
  output chip_cfg_pkg::tio_vec_t       soc_gpio1_o,
  // Debug and UART
  output logic                         soc_swd_clk_o,  // Low unless SYS
  output logic                         soc_swd_dio_o,  // SWDIO into SoC
  input  wire chip_cfg_pkg::pin_drv_t  soc_swd_i,      // SWDIO from SoC
  output logic                         soc_uart_rxd_o, // High unless ALT
  input  wire                          soc_uart_txd_i,
  // Test
  output logic                         soc_test_en_o,
  output chip_cfg_pkg::tio_vec_t       soc_test_in_o,
  input  wire chip_cfg_pkg::tio_vec_t  soc_test_out_i
);

  import chip_cfg_pkg::*;

  logic test_mode; // Scan or BIST

  assign test_mode = sel_i.scan | sel_i.bist;

  //----------------------------------------------------------
  // Alternate pins
  //----------------------------------------------------------
  assign soc_swd_clk_o  = sel_i.sys & pad_altin_i;
  assign soc_swd_dio_o  = sel_i.sys & pad_altio_i;
  assign soc_uart_rxd_o = !sel_i.alt | pad_altin_i; // Idle high

  assign pad_altio_o.o = (sel_i.sys & soc_swd_i.o) | (sel_i.alt & soc_uart_txd_i);
  assign pad_altio_o.e = (sel_i.sys & soc_swd_i.e) | sel_i.alt; // TXD always driven

  //----------------------------------------------------------
  // Test access
  //----------------------------------------------------------
  assign soc_test_en_o = test_mode & pad_altin_i;
  assign soc_test_in_o = test_mode ? pad_gpio0_i : '0;

  //----------------------------------------------------------
  // GPIO groups
  //----------------------------------------------------------
  // Group 0 turns into test input, pad drivers off
  assign pad_gpio0_o = test_mode ? gpio_drv_t'('0) : soc_gpio0_i;

  // Group 1 carries test results out
  assign pad_gpio1_o.o = test_mode ? soc_test_out_i : soc_gpio1_i.o;
  assign pad_gpio1_o.e = test_mode ? {GPIO_TIO{1'b1}} : soc_gpio1_i.e;

  // Pad inputs always visible to the SoC
  assign soc_gpio0_o = pad_gpio0_i;
  assign soc_gpio1_o = pad_gpio1_i;

  // No contention on group 0 while test data is driven in
  always_comb begin
    if (test_mode) begin
      gpio0_off_a : assert (pad_gpio0_o.e == '0)
        else $error("group 0 pad driven in test mode");
    end
  end

endmodule

`default_nettype wire

//--- design/chip_cfg_top.sv
//----------------------------------------------------------
// Chip pad configuration top level
// Reset sequencer, TEST strap sampler, mode latch and pad
// multiplexer in a chain
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module chip_cfg_top (
  input  wire                          pad_clk_i,
  input  wire                          pad_nrst_i,
  input  wire                          pad_test_i,
  // Alternate pins
  input  wire                          pad_altin_i,
  input  wire                          pad_altio_i,
  output chip_cfg_pkg::pin_drv_t       pad_altio_o,
  // GPIO group 0
  input  wire chip_cfg_pkg::tio_vec_t  pad_gpio0_i,
  output chip_cfg_pkg::gpio_drv_t      pad_gpio0_o,
  input  wire chip_cfg_pkg::gpio_drv_t soc_gpio0_i,
  output chip_cfg_pkg::tio_vec_t       soc_gpio0_o,
  // GPIO group 1
  input  wire chip_cfg_pkg::tio_vec_t  pad_gpio1_i,
  output chip_cfg_pkg::gpio_drv_t      pad_gpio1_o,
  input  wire chip_cfg_pkg::gpio_drv_t soc_gpio1_i,
  output chip_cfg_pkg::tio_vec_t       soc_gpio1_o,
  // Debug and UART
  output logic                         soc_swd_clk_o,
  output logic                         soc_swd_dio_o,
  input  wire chip_cfg_pkg::pin_drv_t  soc_swd_i,
  output logic                         soc_uart_rxd_o,
  input  wire                          soc_uart_txd_i,
  // Test
  output logic                         soc_test_en_o,
  output chip_cfg_pkg::tio_vec_t       soc_test_in_o,
  input  wire chip_cfg_pkg::tio_vec_t  soc_test_out_i,
  // SoC control
  output logic                         soc_nreset_o,
  output chip_cfg_pkg::cfg_sel_t       soc_mode_o  // Captured one-hot mode
);

  import chip_cfg_pkg::*;

  logic      nrst_early;  // Config state reset
  logic      strap_win;   // Strap shifting window
  logic      sample_stb;  // Candidate update
  logic      capture_stb; // Mode capture
  cfg_mode_e cfg_mode;    // Sampler to latch

  por_sequencer por_sequencer_inst (
    .pad_clk_i     (pad_clk_i),
    .pad_nrst_i    (pad_nrst_i),
    .nrst_early_o  (nrst_early),
    .strap_win_o   (strap_win),
    .sample_stb_o  (sample_stb),
    .capture_stb_o (capture_stb),
    .soc_nreset_o  (soc_nreset_o)
  );

  test_strap_sampler test_strap_sampler_inst (
    .pad_clk_i    (pad_clk_i),
    .pad_nrst_i   (pad_nrst_i),
    .nrst_early   (nrst_early),
    .pad_test_i   (pad_test_i),
    .strap_win_i  (strap_win),
    .sample_stb_i (sample_stb),
    .mode_o       (cfg_mode)
  );

  cfg_mode_latch cfg_mode_latch_inst (
    .pad_clk_i     (pad_clk_i),
    .nrst_early    (nrst_early),
    .capture_stb_i (capture_stb),
    .mode_i        (cfg_mode),
    .sel_o         (soc_mode_o)
  );

  pad_mux pad_mux_inst (
    .sel_i          (soc_mode_o),
    .pad_altin_i    (pad_altin_i),
    .pad_altio_i    (pad_altio_i),
    .pad_altio_o    (pad_altio_o),
    .pad_gpio0_i    (pad_gpio0_i),
    .pad_gpio0_o    (pad_gpio0_o),
    .soc_gpio0_i    (soc_gpio0_i),
    .soc_gpio0_o    (soc_gpio0_o),
    .pad_gpio1_i    (pad_gpio1_i),
    .pad_gpio1_o    (pad_gpio1_o),
    .soc_gpio1_i    (soc_gpio1_i),
    .soc_gpio1_o    (soc_gpio1_o),
    .soc_swd_clk_o  (soc_swd_clk_o),
    .soc_swd_dio_o  (soc_swd_dio_o),
    .soc_swd_i      (soc_swd_i),
    .soc_uart_rxd_o (soc_uart_rxd_o),
    .soc_uart_txd_i (soc_uart_txd_i),
    .soc_test_en_o  (soc_test_en_o),
    .soc_test_in_o  (soc_test_in_o),
    .soc_test_out_i (soc_test_out_i)
  );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
//----------------------------------------------------------
// Testbench clock generator
// Free-running 4 ns clock for the pad clock input
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o // Pad clock to the DUT
);

  localparam real HALF_PERIOD = 2.0; // 4 ns period

  initial begin
    clk_o = 1'b0; // Rising edges at 2, 6, 10 ns
    forever begin
      #(HALF_PERIOD);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_chip_cfg.sv
//----------------------------------------------------------
// Pad configuration testbench
// Directed tests of the reset timing and the four TEST
// strap modes, with random pad and SoC data on the pins
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_chip_cfg;

  import chip_cfg_pkg::*;

  localparam int RESET_CYCLES = 4;  // Pad reset length
  localparam int WAIT_LIMIT   = 40; // Edges before a wait gives up
  localparam int ROUNDS       = 8;  // Random rounds per mode

  logic        pad_clk;
  logic        pad_nrst;
  logic        pad_test;
  logic        pad_altin;
  logic        pad_altio;
  pin_drv_t    pad_altio_drv;  // DUT drive on the alternate pad
  tio_vec_t    pad_gpio0;
  tio_vec_t    pad_gpio1;
  gpio_drv_t   pad_gpio0_drv;
  gpio_drv_t   pad_gpio1_drv;
  gpio_drv_t   soc_gpio0;      // SoC side drive
  gpio_drv_t   soc_gpio1;
  tio_vec_t    soc_gpio0_rd;   // Pad data seen by the SoC
  tio_vec_t    soc_gpio1_rd;
  logic        swd_clk;
  logic        swd_dio;
  pin_drv_t    soc_swd;
  logic        uart_rxd;
  logic        uart_txd;
  logic        test_en;
  tio_vec_t    test_in;
  tio_vec_t    test_out;
  logic        soc_nreset;
  cfg_sel_t    soc_mode;

  tb_clk_gen tb_clk_gen_inst (.clk_o(pad_clk));

  chip_cfg_top chip_cfg_top_inst (
    .pad_clk_i      (pad_clk),
    .pad_nrst_i     (pad_nrst),
    .pad_test_i     (pad_test),
    .pad_altin_i    (pad_altin),
    .pad_altio_i    (pad_altio),
    .pad_altio_o    (pad_altio_drv),
    .pad_gpio0_i    (pad_gpio0),
    .pad_gpio0_o    (pad_gpio0_drv),
    .soc_gpio0_i    (soc_gpio0),
    .soc_gpio0_o    (soc_gpio0_rd),
    .pad_gpio1_i    (pad_gpio1),
    .pad_gpio1_o    (pad_gpio1_drv),
    .soc_gpio1_i    (soc_gpio1),
    .soc_gpio1_o    (soc_gpio1_rd),
    .soc_swd_clk_o  (swd_clk),
    .soc_swd_dio_o  (swd_dio),
    .soc_swd_i      (soc_swd),
    .soc_uart_rxd_o (uart_rxd),
    .soc_uart_txd_i (uart_txd),
    .soc_test_en_o  (test_en),
    .soc_test_in_o  (test_in),
    .soc_test_out_i (test_out),
    .soc_nreset_o   (soc_nreset),
    .soc_mode_o     (soc_mode)
  );

  //----------------------------------------------------------
  // Error stop and compare tasks
  //----------------------------------------------------------
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s got %b expected %b",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_vec(input string name, input tio_vec_t got, input tio_vec_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s got %h expected %h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_gpio(input string name, input gpio_drv_t got, input gpio_drv_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s got o=%h e=%h expected o=%h e=%h",
                         $time, name, got.o, got.e, exp.o, exp.e));
    end
  endtask

  task automatic check_sel(input string name, input cfg_sel_t got, input cfg_sel_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s got %b expected %b",
                         $time, name, got, exp));
    end
  endtask

  //----------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------
  function automatic logic rand_bit();
    logic [31:0] r;
    r = $urandom();
    return r[0];
  endfunction

  function automatic tio_vec_t rand_vec();
    logic [31:0] r;
    r = $urandom();
    return r[GPIO_TIO-1:0];
  endfunction

  task automatic step(); // Drive point, 1 ns after the edge
    @(posedge pad_clk);
    #1;
  endtask

  task automatic randomize_pins();
    pad_altin = rand_bit();
    pad_altio = rand_bit();
    soc_swd   = {rand_bit(), rand_bit()};
    uart_txd  = rand_bit();
    pad_gpio0 = rand_vec();
    pad_gpio1 = rand_vec();
    soc_gpio0 = {rand_vec(), rand_vec()};
    soc_gpio1 = {rand_vec(), rand_vec()};
    test_out  = rand_vec();
  endtask

  // Pad reset for four cycles, ends right at the release
  task automatic hold_reset(input logic start_lvl);
    cfg_sel_t idle_sel;
    idle_sel = '0;
    step();
    pad_nrst = 1'b0;
    pad_test = start_lvl;
    repeat (RESET_CYCLES - 1) step();
    @(negedge pad_clk);
    check_bit("soc_nreset_o", soc_nreset, 1'b0);
    check_sel("soc_mode_o", soc_mode, idle_sel);
    step();
    pad_nrst = 1'b1;
  endtask

  task automatic wait_soc_reset();
    int edges;
    edges = 0;
    while (soc_nreset !== 1'b1) begin
      if (edges >= WAIT_LIMIT) begin
        fail_run("soc_nreset_o never rose after the pad reset release");
      end else begin
        @(posedge pad_clk);
        edges++;
        @(negedge pad_clk);
      end
    end
  endtask

  // TEST sits at start_lvl through edge 1, end_lvl from then on
  task automatic start_mode(input logic start_lvl, input logic end_lvl);
    hold_reset(start_lvl);
    step();
    pad_test = end_lvl;
    wait_soc_reset();
  endtask

  task automatic check_soc_inputs(); // Pad data always reaches the SoC
    check_vec("soc_gpio0_o", soc_gpio0_rd, pad_gpio0);
    check_vec("soc_gpio1_o", soc_gpio1_rd, pad_gpio1);
  endtask

  //----------------------------------------------------------
  // Directed tests
  //----------------------------------------------------------
  task automatic test_reset_timing();
    int       edges;
    cfg_sel_t exp_sel;
    hold_reset(1'b0);
    edges = 0;
    while (soc_nreset !== 1'b1) begin
      if (edges >= WAIT_LIMIT) begin
        fail_run("soc_nreset_o never rose in the reset timing test");
      end else begin
        step();
        pad_altin = rand_bit(); // Must not leak before capture
        edges++;
        @(negedge pad_clk);
        exp_sel     = '0;
        exp_sel.sys = (edges > 6); // Loaded on edge 7
        check_sel("soc_mode_o", soc_mode, exp_sel);
        if (edges <= 6) begin
          check_bit("soc_swd_clk_o", swd_clk, 1'b0);
          check_bit("soc_uart_rxd_o", uart_rxd, 1'b1);
        end
      end
    end
    if (edges != 8) begin
      fail_run($sformatf("soc_nreset_o rose %0d edges after the release, not 8", edges));
    end
  endtask

  task automatic test_sys_mode();
    cfg_sel_t exp_sel;
    start_mode(1'b0, 1'b0); // Low throughout
    exp_sel     = '0;
    exp_sel.sys = 1'b1;
    repeat (ROUNDS) begin
      step();
      randomize_pins();
      @(negedge pad_clk);
      check_sel("soc_mode_o", soc_mode, exp_sel);
      check_bit("soc_swd_clk_o", swd_clk, pad_altin);
      check_bit("soc_swd_dio_o", swd_dio, pad_altio);
      check_bit("pad_altio_o.o", pad_altio_drv.o, soc_swd.o);
      check_bit("pad_altio_o.e", pad_altio_drv.e, soc_swd.e);
      check_bit("soc_uart_rxd_o", uart_rxd, 1'b1);
      check_gpio("pad_gpio0_o", pad_gpio0_drv, soc_gpio0);
      check_gpio("pad_gpio1_o", pad_gpio1_drv, soc_gpio1);
      check_soc_inputs();
    end
  endtask

  task automatic test_alt_mode();
    cfg_sel_t exp_sel;
    start_mode(1'b0, 1'b1); // Rises at the release
    exp_sel     = '0;
    exp_sel.alt = 1'b1;
    repeat (ROUNDS) begin
      step();
      randomize_pins();
      @(negedge pad_clk);
      check_sel("soc_mode_o", soc_mode, exp_sel);
      check_bit("soc_uart_rxd_o", uart_rxd, pad_altin);
      check_bit("pad_altio_o.o", pad_altio_drv.o, uart_txd);
      check_bit("pad_altio_o.e", pad_altio_drv.e, 1'b1);
      check_bit("soc_swd_clk_o", swd_clk, 1'b0);
      check_gpio("pad_gpio0_o", pad_gpio0_drv, soc_gpio0);
      check_gpio("pad_gpio1_o", pad_gpio1_drv, soc_gpio1);
      check_soc_inputs();
    end
  endtask

  // Scan when TEST stays high, BIST when it falls at the release
  task automatic test_test_mode(input logic end_lvl);
    cfg_sel_t  exp_sel;
    gpio_drv_t exp_gpio;
    start_mode(1'b1, end_lvl);
    exp_sel      = '0;
    exp_sel.scan = end_lvl;
    exp_sel.bist = !end_lvl;
    repeat (ROUNDS) begin
      step();
      randomize_pins();
      @(negedge pad_clk);
      exp_gpio.o = test_out;
      exp_gpio.e = '1;
      check_sel("soc_mode_o", soc_mode, exp_sel);
      check_vec("soc_test_in_o", test_in, pad_gpio0);
      check_vec("pad_gpio0_o.e", pad_gpio0_drv.e, '0);
      check_gpio("pad_gpio1_o", pad_gpio1_drv, exp_gpio);
      check_bit("soc_test_en_o", test_en, pad_altin);
      check_soc_inputs();
    end
  endtask

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    void'($urandom(9185));
    pad_nrst  = 1'b0;
    pad_test  = 1'b0;
    pad_altin = 1'b0;
    pad_altio = 1'b0;
    soc_swd   = '0;
    uart_txd  = 1'b0;
    pad_gpio0 = '0;
    pad_gpio1 = '0;
    soc_gpio0 = '0;
    soc_gpio1 = '0;
    test_out  = '0;
    test_reset_timing();
    test_sys_mode();
    test_alt_mode();
    test_test_mode(1'b1); // Scan
    test_test_mode(1'b0); // BIST
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
design/chip_cfg_pkg.sv
design/por_sequencer.sv
design/test_strap_sampler.sv
design/cfg_mode_latch.sv
design/pad_mux.sv
design/chip_cfg_top.sv
verif/tb_clk_gen.sv
verif/tb_chip_cfg.sv

//--- run.sh
#!/bin/sh
# Build and run the pad configuration testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_chip_cfg -f tb.f -o tb_chip_cfg || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_chip_cfg 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
